/* verilog/mm_types_pkg.sv */
// matrix and array types for the accelerator
// shared by the systolic datapath and the dma engine
package mm_types_pkg;

    // array size, also the matrix dimension
    localparam int SA_N = 4;

    // operand element width, signed
    localparam int ELEM_W = 8;

    // accumulator and result width, signed
    localparam int ACC_W = 32;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // one bus word, seen raw or as four element lanes
    // lane 0 sits in the low byte
    typedef union packed {
        logic [SA_N*ELEM_W-1:0] raw;
        elem_t [SA_N-1:0]       lane;
    } bus_word_t;

endpackage

/* verilog/mem_bus_pkg.sv */
// memory bus constants
// fixed bursts, one matrix row per data beat
package mem_bus_pkg;

    // data beat width
    localparam int BUS_W = 32;

    // beats per operand read burst
    localparam int RD_BEATS = 4;
    // beats per result write burst
    localparam int WR_BEATS = 16;

    // read ids that steer returning beats
    localparam logic ID_A = 1'b0;
    localparam logic ID_B = 1'b1;

endpackage

/* verilog/pe.sv */
`timescale 1ns/1ps

// systolic processing element
// multiply-accumulate, passes a to the right and b downward
module pe
    import mm_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear_i,
    input  elem_t a_i,
    input  elem_t b_i,
    output elem_t a_o,
    output elem_t b_o,
    output acc_t  acc_o
);

    // signed product, sign extended to accumulator width
    acc_t prod;

    assign prod = a_i * b_i;

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            a_o   <= '0;
            b_o   <= '0;
            acc_o <= '0;
        end else begin
            // zero operands at the skew edges add nothing
            acc_o <= acc_o + prod;
            // one cycle to each neighbour
            a_o   <= a_i;
            b_o   <= b_i;
        end
    end

endmodule

/* verilog/skew_feeder.sv */
`timescale 1ns/1ps

// skew feeder for the systolic array
// stores rows of a and columns of b, feeds them staggered by one cycle per lane
module skew_feeder
    import mm_types_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mm_start_i,
    input  logic                    wr_a_en_i,
    input  logic                    wr_b_en_i,
    input  logic [$clog2(SA_N)-1:0] wr_idx_i,
    input  bus_word_t               wr_data_i,
    output elem_t [SA_N-1:0]        a_row_o,
    output elem_t [SA_N-1:0]        b_col_o,
    output logic                    clear_o,
    output logic                    mm_done_o
);

    localparam int STEP_W = $clog2(3 * SA_N);
    localparam int IDX_W  = $clog2(SA_N);
    // feed lasts 3n-2 steps, numbered from zero
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(3 * SA_N - 3);

    // row i of a, column j of b
    bus_word_t a_mem [SA_N];
    bus_word_t b_mem [SA_N];

    logic              feeding_q;
    logic [STEP_W-1:0] step_q;

    // operand store, written by the dma engine
    always_ff @(posedge clk) begin
        if (wr_a_en_i) begin
            a_mem[wr_idx_i] <= wr_data_i;
        end
        if (wr_b_en_i) begin
            b_mem[wr_idx_i] <= wr_data_i;
        end
    end

    // start -> clear -> 3n-2 feed steps -> done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clear_o   <= 1'b0;
            feeding_q <= 1'b0;
            step_q    <= '0;
            mm_done_o <= 1'b0;
        end else begin
            clear_o   <= mm_start_i;
            // last product lands in the far corner on the final step
            mm_done_o <= feeding_q && (step_q == LAST_STEP);
            if (clear_o) begin
                feeding_q <= 1'b1;
                step_q    <= '0;
            end else if (feeding_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == LAST_STEP) begin
                    feeding_q <= 1'b0;
                end
            end
        end
    end

    // lane i carries element k on step k+i, zero otherwise
    always_comb begin
        for (int i = 0; i < SA_N; i++) begin
            a_row_o[i] = '0;
            b_col_o[i] = '0;
            if (feeding_q && (step_q >= STEP_W'(i)) && (step_q < STEP_W'(i + SA_N))) begin
                a_row_o[i] = a_mem[i].lane[IDX_W'(step_q - STEP_W'(i))];
                // b is held transposed, so the lane walks down column i
                b_col_o[i] = b_mem[i].lane[IDX_W'(step_q - STEP_W'(i))];
            end
        end
    end

endmodule

/* verilog/dma_engine.sv */
`timescale 1ns/1ps

// dma engine of the matrix accelerator
// reads a and b as two bursts into the feeder, starts the array,
// then writes the 16 accumulators back as one burst
module dma_engine
    import mm_types_pkg::*, mem_bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // base addresses
    input  logic [ADDR_W-1:0]           mat_a_addr_i,
    input  logic [ADDR_W-1:0]           mat_b_addr_i,
    input  logic [ADDR_W-1:0]           mat_c_addr_i,
    input  logic                        start_i,
    output logic                        done_o,
    // read address
    output logic                        arvalid_o,
    input  logic                        arready_i,
    output logic [ADDR_W-1:0]           araddr_o,
    output logic                        arid_o,
    // read data
    input  logic                        rvalid_i,
    output logic                        rready_o,
    input  logic [BUS_W-1:0]            rdata_i,
    input  logic                        rid_i,
    input  logic                        rlast_i,
    // write address
    output logic                        awvalid_o,
    input  logic                        awready_i,
    output logic [ADDR_W-1:0]           awaddr_o,
    // write data
    output logic                        wvalid_o,
    input  logic                        wready_i,
    output logic [BUS_W-1:0]            wdata_o,
    output logic                        wlast_o,
    // write response
    input  logic                        bvalid_i,
    output logic                        bready_o,
    // operand store of the feeder
    output logic                        wr_a_en_o,
    output logic                        wr_b_en_o,
    output logic [$clog2(RD_BEATS)-1:0] wr_idx_o,
    output bus_word_t                   wr_data_o,
    // compute side
    output logic                        mm_start_o,
    input  logic                        mm_done_i,
    input  acc_t [SA_N*SA_N-1:0]        accum_i
);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_AR_A = 3'd1;
    localparam logic [2:0] S_AR_B = 3'd2;
    localparam logic [2:0] S_LOAD = 3'd3;
    localparam logic [2:0] S_COMP = 3'd4;
    localparam logic [2:0] S_AW   = 3'd5;
    localparam logic [2:0] S_W    = 3'd6;
    localparam logic [2:0] S_B    = 3'd7;

    localparam int BEAT_W = $clog2(RD_BEATS);
    localparam int RES_W  = $clog2(WR_BEATS);

    logic [2:0]        state_q;
    logic [2:0]        state_d;
    logic [ADDR_W-1:0] a_base_q;
    logic [ADDR_W-1:0] b_base_q;
    logic [ADDR_W-1:0] c_base_q;
    // beat index per read id
    logic [BEAT_W-1:0] cnt_a_q;
    logic [BEAT_W-1:0] cnt_b_q;
    logic              done_a_q;
    logic              done_b_q;
    // selects the accumulator on the current write beat
    logic [RES_W-1:0]  res_cnt_q;
    logic              r_hs;
    logic              a_last;
    logic              b_last;
    logic              load_end;

    assign r_hs     = rvalid_i && rready_o;
    assign a_last   = r_hs && rlast_i && (rid_i == ID_A);
    assign b_last   = r_hs && rlast_i && (rid_i == ID_B);
    // both bursts complete, counting a last beat in this cycle
    assign load_end = (done_a_q || a_last) && (done_b_q || b_last);

    // bus and store outputs, straight from state
    always_comb begin
        arvalid_o     = (state_q == S_AR_A) || (state_q == S_AR_B);
        arid_o        = (state_q == S_AR_B) ? ID_B : ID_A;
        araddr_o      = (state_q == S_AR_B) ? b_base_q : a_base_q;
        rready_o      = (state_q == S_LOAD);
        awvalid_o     = (state_q == S_AW);
        awaddr_o      = c_base_q;
        wvalid_o      = (state_q == S_W);
        // row-major, C[i][j] at index 4i+j
        wdata_o       = accum_i[res_cnt_q];
        wlast_o       = wvalid_o && (res_cnt_q == RES_W'(WR_BEATS - 1));
        bready_o      = (state_q == S_B);
        done_o        = bready_o && bvalid_i;
        // accepted beats go to the store in the same cycle
        wr_a_en_o     = r_hs && (rid_i == ID_A);
        wr_b_en_o     = r_hs && (rid_i == ID_B);
        wr_idx_o      = (rid_i == ID_B) ? cnt_b_q : cnt_a_q;
        wr_data_o.raw = rdata_i;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    state_d = S_AR_A;
                end
            end
            S_AR_A: begin
                if (arready_i) begin
                    state_d = S_AR_B;
                end
            end
            S_AR_B: begin
                if (arready_i) begin
                    state_d = S_LOAD;
                end
            end
            S_LOAD: begin
                if (load_end) begin
                    state_d = S_COMP;
                end
            end
            S_COMP: begin
                if (mm_done_i) begin
                    state_d = S_AW;
                end
            end
            S_AW: begin
                if (awready_i) begin
                    state_d = S_W;
                end
            end
            S_W: begin
                if (wready_i && wlast_o) begin
                    state_d = S_B;
                end
            end
            default: begin
                // response channel
                if (bvalid_i) begin
                    state_d = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            mm_start_o <= 1'b0;
            cnt_a_q    <= '0;
            cnt_b_q    <= '0;
            done_a_q   <= 1'b0;
            done_b_q   <= 1'b0;
            res_cnt_q  <= '0;
        end else begin
            state_q    <= state_d;
            // one pulse, the cycle after the last read beat
            mm_start_o <= (state_q == S_LOAD) && load_end;
            if (state_q == S_IDLE) begin
                cnt_a_q  <= '0;
                cnt_b_q  <= '0;
                done_a_q <= 1'b0;
                done_b_q <= 1'b0;
            end
            if (wr_a_en_o) begin
                cnt_a_q <= cnt_a_q + 1'b1;
            end
            if (wr_b_en_o) begin
                cnt_b_q <= cnt_b_q + 1'b1;
            end
            if (a_last) begin
                done_a_q <= 1'b1;
            end
            if (b_last) begin
                done_b_q <= 1'b1;
            end
            // result index moves only on a write handshake
            if (state_q == S_AW) begin
                res_cnt_q <= '0;
            end else if (wvalid_o && wready_i) begin
                res_cnt_q <= res_cnt_q + 1'b1;
            end
        end
    end

    // bases held for the whole run
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
        end
    end

endmodule

/* verilog/mm_accel_top.sv */
`timescale 1ns/1ps

// matrix multiply accelerator top level
// dma engine, skew feeder and a 4x4 output-stationary pe array
module mm_accel_top
    import mm_types_pkg::*, mem_bus_pkg::*;
#(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] mat_a_addr_i,
    input  logic [ADDR_W-1:0] mat_b_addr_i,
    input  logic [ADDR_W-1:0] mat_c_addr_i,
    input  logic              start_i,
    output logic              done_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    output logic [ADDR_W-1:0] araddr_o,
    output logic              arid_o,
    input  logic              rvalid_i,
    output logic              rready_o,
    input  logic [BUS_W-1:0]  rdata_i,
    input  logic              rid_i,
    input  logic              rlast_i,
    output logic              awvalid_o,
    input  logic              awready_i,
    output logic [ADDR_W-1:0] awaddr_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output logic [BUS_W-1:0]  wdata_o,
    output logic              wlast_o,
    input  logic              bvalid_i,
    output logic              bready_o
);

    // operand store writes
    logic                    wr_a_en;
    logic                    wr_b_en;
    logic [$clog2(SA_N)-1:0] wr_idx;
    bus_word_t               wr_data;
    // compute control
    logic                    mm_start;
    logic                    mm_done;
    logic                    clear;
    // skewed edge operands
    elem_t [SA_N-1:0]        a_row;
    elem_t [SA_N-1:0]        b_col;
    acc_t [SA_N*SA_N-1:0]    accum;
    // a runs left to right, b top to bottom
    elem_t                   a_h [SA_N][SA_N+1];
    elem_t                   b_v [SA_N+1][SA_N];

    dma_engine #(
        .ADDR_W(ADDR_W)
    ) u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready_i),
        .araddr_o     (araddr_o),
        .arid_o       (arid_o),
        .rvalid_i     (rvalid_i),
        .rready_o     (rready_o),
        .rdata_i      (rdata_i),
        .rid_i        (rid_i),
        .rlast_i      (rlast_i),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready_i),
        .awaddr_o     (awaddr_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready_i),
        .wdata_o      (wdata_o),
        .wlast_o      (wlast_o),
        .bvalid_i     (bvalid_i),
        .bready_o     (bready_o),
        .wr_a_en_o    (wr_a_en),
        .wr_b_en_o    (wr_b_en),
        .wr_idx_o     (wr_idx),
        .wr_data_o    (wr_data),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .accum_i      (accum)
    );

    skew_feeder u_feed (
        .clk        (clk),
        .rst_n      (rst_n),
        .mm_start_i (mm_start),
        .wr_a_en_i  (wr_a_en),
        .wr_b_en_i  (wr_b_en),
        .wr_idx_i   (wr_idx),
        .wr_data_i  (wr_data),
        .a_row_o    (a_row),
        .b_col_o    (b_col),
        .clear_o    (clear),
        .mm_done_o  (mm_done)
    );

    for (genvar i = 0; i < SA_N; i++) begin : g_row
        // row operands enter the left column, column operands the top row
        assign a_h[i][0] = a_row[i];
        assign b_v[0][i] = b_col[i];
        for (genvar j = 0; j < SA_N; j++) begin : g_col
            pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear_i (clear),
                .a_i     (a_h[i][j]),
                .b_i     (b_v[i][j]),
                .a_o     (a_h[i][j+1]),
                .b_o     (b_v[i+1][j]),
                .acc_o   (accum[i*SA_N+j])
            );
        end
    end

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/1ps

// testbench clock and reset
// free running clock, reset held low for the first few rising edges
module clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // released just after an edge, seen by the dut on the next one
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

/* bench/tb_mm_accel.sv */
`timescale 1ns/1ps

// testbench of the matrix multiply accelerator
// bus memory model with random stalls, software reference product, directed runs
module tb_mm_accel
    import mm_types_pkg::*, mem_bus_pkg::*;
();

    localparam int ADDR_W     = 32;
    localparam int CLK_PERIOD = 20;
    localparam int RUN_CYCLES = 400;
    localparam int NUM_RUNS   = 5;
    localparam int MEM_WORDS  = 256;

    logic              clk;
    logic              rst_n;
    logic [ADDR_W-1:0] mat_a_addr;
    logic [ADDR_W-1:0] mat_b_addr;
    logic [ADDR_W-1:0] mat_c_addr;
    logic              start_i;
    logic              done_o;
    logic              arvalid_o;
    logic              arready;
    logic [ADDR_W-1:0] araddr_o;
    logic              arid_o;
    logic              rvalid;
    logic              rready_o;
    logic [BUS_W-1:0]  rdata;
    logic              rid;
    logic              rlast;
    logic              awvalid_o;
    logic              awready;
    logic [ADDR_W-1:0] awaddr_o;
    logic              wvalid_o;
    logic              wready;
    logic [BUS_W-1:0]  wdata_o;
    logic              wlast_o;
    logic              bvalid;
    logic              bready_o;

    // word memory, index is address bits 9:2
    logic [BUS_W-1:0]  mem [MEM_WORDS];
    // pending read bursts, plus a log of every ar request in a run
    logic [ADDR_W-1:0] ar_addr_q [$];
    logic              ar_id_q [$];
    logic [ADDR_W-1:0] ar_addr_log [$];
    logic              ar_id_log [$];
    logic              ar_hs;
    logic              r_hs;
    logic              aw_hs;
    logic              w_hs;
    logic              b_hs;
    logic              r_active;
    logic              r_id;
    logic [ADDR_W-1:0] r_addr;
    int                r_beat;
    int                w_base;
    int                w_cnt;
    logic              b_pending;
    logic [ADDR_W-1:0] cur_c;
    int                done_cnt;
    logic              stall_en;
    logic [15:0]       lfsr = 16'd19278;
    int                check_cnt;
    int                mismatch_cnt;
    int                timeout_cnt;

    clk_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (3)
    ) u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mm_accel_top #(
        .ADDR_W(ADDR_W)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .start_i      (start_i),
        .done_o       (done_o),
        .arvalid_o    (arvalid_o),
        .arready_i    (arready),
        .araddr_o     (araddr_o),
        .arid_o       (arid_o),
        .rvalid_i     (rvalid),
        .rready_o     (rready_o),
        .rdata_i      (rdata),
        .rid_i        (rid),
        .rlast_i      (rlast),
        .awvalid_o    (awvalid_o),
        .awready_i    (awready),
        .awaddr_o     (awaddr_o),
        .wvalid_o     (wvalid_o),
        .wready_i     (wready),
        .wdata_o      (wdata_o),
        .wlast_o      (wlast_o),
        .bvalid_i     (bvalid),
        .bready_o     (bready_o)
    );

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // always ready unless stalls are on, then a coin flip
    function automatic logic ready_bit();
        logic [31:0] r;
        if (!stall_en) begin
            return 1'b1;
        end
        r = rand_bits(1);
        return r[0];
    endfunction

    function automatic int word_idx(input logic [ADDR_W-1:0] addr);
        return int'(addr[9:2]);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            mismatch_cnt++;
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // bus slave, handshakes sampled at negedge where both sides are stable
    initial begin : mem_model
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rid       = 1'b0;
        rlast     = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        r_active  = 1'b0;
        b_pending = 1'b0;
        forever begin
            @(negedge clk);
            ar_hs = arvalid_o && arready;
            r_hs  = rvalid && rready_o;
            aw_hs = awvalid_o && awready;
            w_hs  = wvalid_o && wready;
            b_hs  = bvalid && bready_o;
            if (ar_hs) begin
                ar_addr_q.push_back(araddr_o);
                ar_id_q.push_back(arid_o);
                ar_addr_log.push_back(araddr_o);
                ar_id_log.push_back(arid_o);
            end
            if (aw_hs) begin
                check(awaddr_o, cur_c, "awaddr");
                w_base = word_idx(awaddr_o);
                w_cnt  = 0;
            end
            if (w_hs) begin
                // wlast only on the 16th beat
                check(32'(wlast_o), 32'(w_cnt == WR_BEATS - 1), "wlast");
                if (w_cnt < WR_BEATS) begin
                    mem[w_base + w_cnt] = wdata_o;
                end
                w_cnt++;
                if (wlast_o) begin
                    b_pending = 1'b1;
                end
            end
            if (done_o === 1'b1) begin
                done_cnt++;
            end
            @(posedge clk);
            #1;
            arready = ready_bit();
            awready = ready_bit();
            wready  = ready_bit();
            // read bursts in request order, valid held until taken
            if (r_hs) begin
                rvalid = 1'b0;
                r_beat++;
                if (r_beat == RD_BEATS) begin
                    r_active = 1'b0;
                end
            end
            if (!r_active && ar_addr_q.size() > 0) begin
                r_addr   = ar_addr_q.pop_front();
                r_id     = ar_id_q.pop_front();
                r_beat   = 0;
                r_active = 1'b1;
            end
            if (r_active && !rvalid) begin
                rvalid = ready_bit();
            end
            if (r_active) begin
                rdata = mem[word_idx(r_addr) + r_beat];
                rid   = r_id;
                rlast = (r_beat == RD_BEATS - 1);
            end
            // write response after the last beat
            if (b_hs) begin
                bvalid    = 1'b0;
                b_pending = 1'b0;
            end
            if (b_pending && !bvalid) begin
                bvalid = ready_bit();
            end
        end
    end

    // one start pulse, then wait for done with a cycle limit
    task automatic run_mm(input logic [ADDR_W-1:0] a_base, input logic [ADDR_W-1:0] b_base,
                          input logic [ADDR_W-1:0] c_base);
        int   n;
        int   done_before;
        logic got;
        n           = 0;
        got         = 1'b0;
        done_before = done_cnt;
        cur_c       = c_base;
        ar_addr_log.delete();
        ar_id_log.delete();
        @(posedge clk);
        #1;
        mat_a_addr = a_base;
        mat_b_addr = b_base;
        mat_c_addr = c_base;
        start_i    = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        while (!got && n < RUN_CYCLES) begin
            @(negedge clk);
            got = (done_o === 1'b1);
            n++;
        end
        if (!got) begin
            timeout_cnt++;
            $display("timeout at %0t ns: done_o never came within %0d cycles", $time, RUN_CYCLES);
        end
        // done is a single cycle pulse
        @(negedge clk);
        check(32'(done_o), 32'd0, "done_o after pulse");
        @(posedge clk);
        #1;
        check(done_cnt, done_before + 1, "done pulses in run");
        check(ar_addr_log.size(), 2, "ar requests in run");
        if (ar_addr_log.size() == 2) begin
            // a first with id 0, then b with id 1
            check(ar_addr_log[0], a_base, "first araddr");
            check(32'(ar_id_log[0]), 32'(ID_A), "first arid");
            check(ar_addr_log[1], b_base, "second araddr");
            check(32'(ar_id_log[1]), 32'(ID_B), "second arid");
        end
        check(w_cnt, WR_BEATS, "w beats in run");
    endtask

    task automatic fill_random(input logic [ADDR_W-1:0] a_base, input logic [ADDR_W-1:0] b_base);
        bus_word_t w;
        for (int i = 0; i < SA_N; i++) begin
            mem[word_idx(a_base) + i] = rand_bits(32);
            mem[word_idx(b_base) + i] = rand_bits(32);
        end
        // a few -128 corners
        w.raw      = mem[word_idx(a_base)];
        w.lane[0]  = elem_t'(-128);
        mem[word_idx(a_base)] = w.raw;
        w.raw      = mem[word_idx(b_base)];
        w.lane[0]  = elem_t'(-128);
        mem[word_idx(b_base)] = w.raw;
        w.raw      = mem[word_idx(a_base) + 3];
        w.lane[2]  = elem_t'(-128);
        mem[word_idx(a_base) + 3] = w.raw;
    endtask

    // reference, C[i][j] = sum over k of A row i lane k times B column j lane k
    task automatic check_product(input logic [ADDR_W-1:0] a_base,
                                 input logic [ADDR_W-1:0] b_base,
                                 input logic [ADDR_W-1:0] c_base);
        bus_word_t aw;
        bus_word_t bw;
        acc_t      exp;
        for (int i = 0; i < SA_N; i++) begin
            for (int j = 0; j < SA_N; j++) begin
                aw.raw = mem[word_idx(a_base) + i];
                bw.raw = mem[word_idx(b_base) + j];
                exp    = '0;
                for (int k = 0; k < SA_N; k++) begin
                    exp = exp + acc_t'(aw.lane[k]) * acc_t'(bw.lane[k]);
                end
                check(mem[word_idx(c_base) + SA_N * i + j], exp,
                      $sformatf("C[%0d][%0d]", i, j));
            end
        end
    endtask

    task automatic after_reset_idle();
        repeat (8) begin
            @(negedge clk);
            check({arvalid_o, rready_o, awvalid_o, wvalid_o, bready_o, done_o}, '0,
                  "bus outputs before start");
        end
        check(done_cnt, 0, "done pulses before start");
    endtask

    // identity a, so c must equal b as row-major 32-bit words
    task automatic identity_product();
        bus_word_t w;
        for (int i = 0; i < SA_N; i++) begin
            w.raw     = '0;
            w.lane[i] = elem_t'(1);
            mem[word_idx(32'h000) + i] = w.raw;
            for (int k = 0; k < SA_N; k++) begin
                w.lane[k] = elem_t'((i * SA_N + k) * 13 - 100);
            end
            mem[word_idx(32'h010) + i] = w.raw;
        end
        run_mm(32'h000, 32'h010, 32'h040);
        for (int i = 0; i < SA_N; i++) begin
            for (int j = 0; j < SA_N; j++) begin
                // b column j holds B[i][j] in lane i
                w.raw = mem[word_idx(32'h010) + j];
                check(mem[word_idx(32'h040) + SA_N * i + j], acc_t'(w.lane[i]),
                      $sformatf("identity C[%0d][%0d]", i, j));
            end
        end
    endtask

    task automatic random_product();
        fill_random(32'h100, 32'h120);
        run_mm(32'h100, 32'h120, 32'h180);
        check_product(32'h100, 32'h120, 32'h180);
    endtask

    task automatic stalled_product();
        fill_random(32'h200, 32'h210);
        @(negedge clk);
        stall_en = 1'b1;
        run_mm(32'h200, 32'h210, 32'h240);
        @(negedge clk);
        stall_en = 1'b0;
        check_product(32'h200, 32'h210, 32'h240);
    endtask

    // second run only matches if the accumulators were cleared
    task automatic back_to_back_runs();
        fill_random(32'h300, 32'h310);
        fill_random(32'h020, 32'h030);
        run_mm(32'h300, 32'h310, 32'h340);
        run_mm(32'h020, 32'h030, 32'h0c0);
        check_product(32'h300, 32'h310, 32'h340);
        check_product(32'h020, 32'h030, 32'h0c0);
    endtask

    initial begin : main
        check_cnt    = 0;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        done_cnt     = 0;
        stall_en     = 1'b0;
        start_i      = 1'b0;
        mat_a_addr   = '0;
        mat_b_addr   = '0;
        mat_c_addr   = '0;
        cur_c        = '0;
        w_cnt        = 0;
        // fill pattern from the whole word index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {8'ha5, 8'(i), ~8'(i), 8'(i)};
        end
        wait (rst_n === 1'b1);
        after_reset_idle();
        identity_product();
        random_product();
        stalled_product();
        back_to_back_runs();
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_cnt, mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // limit of all runs plus reset margin
    initial begin : watchdog
        #((NUM_RUNS * RUN_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired at %0t ns, the tests did not complete", $time);
        $display("Something failed");
        $finish;
    end

endmodule

/* src.f */
verilog/mm_types_pkg.sv
verilog/mem_bus_pkg.sv
verilog/pe.sv
verilog/skew_feeder.sv
verilog/dma_engine.sv
verilog/mm_accel_top.sv
bench/clk_gen.sv
bench/tb_mm_accel.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator, then search the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_mm_accel -o tb_mm_accel \
    && ./obj_dir/tb_mm_accel > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "no result in log"; exit 1; }
exit 0
